/* videoInput.hex */
// groups are {Cb, Y1, Cr, Y2}; per field four line-1 groups, four line-3 groups,
// the skipped group, the skipped-line group, then eight expected 5-6-5 words in address order
// field 1
80FF8020 80808020 80058020 1080F020
80408020 80C08020 C0604020 80A08020
80D080D0 80308030
0000CE59 0000738E 00000000 0000630C
00002104 0000AD55 0000528A 00008C51
// field 2
80788010 60B06010 80208010 F0D88010
F030F010 80EB8010 80588010 80908010
80488048 80688068
00005ACB 00009CD3 00000841 0000AD55
00004A49 0000CE59 00004208 00007BCF

/* project.f */
videoPkg.sv
hostPkg.sv
sampleIf.sv
pixelWriteIf.sv
videoSync.sv
ycbcrDecode.sv
frameWriter.sv
frameBuffer.sv
videoCapture.sv
tbVideoCapture.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbVideoCapture -f project.f -o simVideo
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simVideo > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

/* tbVideoCapture.sv */
// needs videoInput.hex in the working directory; DUT runs with PixelsPerLine 4 and DecimGroups 2
`timescale 1ns/1ps
`default_nettype none

module tbVideoCapture import videoPkg::*, hostPkg::*; ();

	localparam int GroupsPerLine = 8;
	localparam int FieldEntries = 18;
	localparam int WordsPerField = 8;
	localparam int IrqTimeout = 200;
	localparam int ReadTimeout = 40;

	logic clk_llc;
	logic resetx;
	logic vref;
	logic href;
	logic odd;
	byteT vpo;
	logic hostCsx;
	logic hostRdx;
	wordAddrT hostAddr;
	wordT hostData;
	logic hostWaitx;
	logic irq0;
	logic irq1;

	// each field holds the kept groups of lines 1 and 3, two filler groups and the expected words
	logic [31:0] stim [0:2*FieldEntries-1];
	int errCount;
	int timeoutCount;
	int checkCount;

	videoCapture #(
		.PixelsPerLine(4),
		.DecimGroups(2)
	) u_dut (
		.clk_llc(clk_llc),
		.resetx(resetx),
		.vref(vref),
		.href(href),
		.odd(odd),
		.vpo(vpo),
		.hostCsx(hostCsx),
		.hostRdx(hostRdx),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostWaitx(hostWaitx),
		.irq0(irq0),
		.irq1(irq1)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #20 clk_llc = ~clk_llc;
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic checkWord(input string name, input wordT got, input wordT exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkIrq(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkBank(input string name, input bankT got, input bankT exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// --------------------------------------------------
	// video stream driver
	// --------------------------------------------------
	// bytes go out Cb first at one per clock
	task automatic driveGroup(input logic [31:0] grp);
		int b;
		for (b = 3; b >= 0; b--)
		begin
			@(posedge clk_llc);
			href <= 1'b1;
			vpo <= grp[8*b +: 8];
		end
	endtask

	task automatic driveLine(input int groupBase, input logic keptLine, input int fieldBase);
		int g;
		for (g = 0; g < GroupsPerLine; g++)
		begin
			if (!keptLine)
				driveGroup(stim[fieldBase + 9]);
			else if (g % 2 == 0)
				driveGroup(stim[groupBase + g / 2]);
			else
				driveGroup(stim[fieldBase + 8]);
		end
		@(posedge clk_llc);
		href <= 1'b0;
		vpo <= 8'h10;
		repeat (6) @(posedge clk_llc);
	endtask

	// three lines with the skipped one in the middle
	task automatic streamField(input int fieldBase, input logic oddLevel);
		@(posedge clk_llc);
		odd <= oddLevel;
		vref <= 1'b1;
		repeat (4) @(posedge clk_llc);
		driveLine(fieldBase, 1'b1, fieldBase);
		driveLine(fieldBase, 1'b0, fieldBase);
		driveLine(fieldBase + 4, 1'b1, fieldBase);
		@(posedge clk_llc);
		vref <= 1'b0;
		odd <= 1'b0;
		repeat (2) @(posedge clk_llc);
	endtask

	// --------------------------------------------------
	// host side
	// --------------------------------------------------
	task automatic readWord(input wordAddrT addr, output wordT data);
		int cnt;
		@(posedge clk_llc);
		hostAddr <= addr;
		hostCsx <= 1'b0;
		hostRdx <= 1'b0;
		cnt = 0;
		@(negedge clk_llc);
		while (hostWaitx !== 1'b1 && cnt < ReadTimeout)
		begin
			@(negedge clk_llc);
			cnt++;
		end
		if (hostWaitx !== 1'b1)
		begin
			timeoutCount++;
			$display("timeout: hostWaitx never rose on the read of address 0x%h", addr);
		end
		data = hostData;
		@(posedge clk_llc);
		hostCsx <= 1'b1;
		hostRdx <= 1'b1;
		// let ready clear before the next read
		repeat (4) @(posedge clk_llc);
	endtask

	task automatic compareFieldWords(input int fieldBase);
		wordT got;
		int a;
		for (a = 0; a < WordsPerField; a++)
		begin
			readWord(wordAddrT'(a), got);
			checkWord($sformatf("hostData[%0d]", a), got, stim[fieldBase + 10 + a][15:0]);
		end
	endtask

	// irq of the completed bank stays high for two cycles
	task automatic waitFieldIrq(input bankT expBank);
		int cnt;
		int i;
		logic hi;
		cnt = 0;
		@(negedge clk_llc);
		while (!(irq0 || irq1) && cnt < IrqTimeout)
		begin
			@(negedge clk_llc);
			cnt++;
		end
		if (!(irq0 || irq1))
		begin
			timeoutCount++;
			$display("timeout: no field interrupt after the end of the field");
		end
		else
		begin
			checkBank("completed bank", irq1 ? Bank1 : Bank0, expBank);
			for (i = 0; i < 3; i++)
			begin
				hi = (i < 2);
				checkIrq("irq0", irq0, hi && (expBank == Bank0));
				checkIrq("irq1", irq1, hi && (expBank == Bank1));
				@(negedge clk_llc);
			end
		end
	endtask

	task automatic watchQuiet(input int cycles);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			@(negedge clk_llc);
			checkIrq("irq0", irq0, 1'b0);
			checkIrq("irq1", irq1, 1'b0);
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		wordT got;
		errCount = 0;
		timeoutCount = 0;
		checkCount = 0;
		resetx <= 1'b0;
		vref <= 1'b0;
		href <= 1'b0;
		odd <= 1'b0;
		vpo <= 8'h10;
		hostCsx <= 1'b1;
		hostRdx <= 1'b1;
		hostAddr <= '0;
		$readmemh("videoInput.hex", stim);
		repeat (8) @(posedge clk_llc);
		resetx <= 1'b1;
		repeat (2) @(posedge clk_llc);
		@(negedge clk_llc);
		checkIrq("irq0", irq0, 1'b0);
		checkIrq("irq1", irq1, 1'b0);
		checkIrq("hostWaitx", hostWaitx, 1'b1);

		// field 1 lands in bank 0
		streamField(0, 1'b1);
		waitFieldIrq(Bank0);
		compareFieldWords(0);

		// even field must be ignored
		streamField(FieldEntries, 1'b0);
		watchQuiet(20);

		// field 2 lands in bank 1
		streamField(FieldEntries, 1'b1);
		waitFieldIrq(Bank1);
		compareFieldWords(FieldEntries);

		// field 3 goes to bank 0 while the host still reads bank 1
		fork
			streamField(0, 1'b1);
			begin
				// synchronised request meets the first write of field 3
				repeat (11) @(posedge clk_llc);
				readWord(wordAddrT'(2), got);
				checkWord("hostData[2]", got, stim[FieldEntries + 12][15:0]);
			end
		join
		waitFieldIrq(Bank0);

		$display("checks %0d, value errors %0d, timeouts %0d", checkCount, errCount,
			timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* videoCapture.sv */
// single clk_llc domain; a kept byte group reaches the memory 5 cycles after its Cr byte is sampled
`timescale 1ns/1ps
`default_nettype none

module videoCapture import videoPkg::*, hostPkg::*; #(
	parameter int PixelsPerLine = 180,
	parameter int DecimGroups = 2
) (
	input  logic     clk_llc,
	input  logic     resetx,
	input  logic     vref,
	input  logic     href,
	input  logic     odd,
	input  byteT     vpo,
	input  logic     hostCsx,
	input  logic     hostRdx,
	input  wordAddrT hostAddr,
	output wordT     hostData,
	output logic     hostWaitx,
	output logic     irq0,
	output logic     irq1
);

	logic wrEn;
	wordAddrT wrAddr;
	bankT wrBank;
	wordT wrData;

	sampleIf sampleBus ();
	pixelWriteIf pixelBus ();

	videoSync #(.DecimGroups(DecimGroups)) uSync (
		.clk_llc(clk_llc),
		.resetx(resetx),
		.vref(vref),
		.href(href),
		.odd(odd),
		.vpo(vpo),
		.sample(sampleBus.src)
	);

	ycbcrDecode uDecode (
		.clk_llc(clk_llc),
		.resetx(resetx),
		.sample(sampleBus.dst),
		.pixel(pixelBus.src)
	);

	frameWriter #(.PixelsPerLine(PixelsPerLine)) uWriter (
		.clk_llc(clk_llc),
		.resetx(resetx),
		.pixel(pixelBus.dst),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrBank(wrBank),
		.wrData(wrData),
		.irq0(irq0),
		.irq1(irq1)
	);

	frameBuffer uBuffer (
		.clk_llc(clk_llc),
		.resetx(resetx),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrBank(wrBank),
		.wrData(wrData),
		.hostCsx(hostCsx),
		.hostRdx(hostRdx),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostWaitx(hostWaitx)
	);

endmodule

`default_nettype wire

/* frameBuffer.sv */
// host reads the bank not being written; read latency is at least 4 clk_llc after hostRdx falls
`timescale 1ns/1ps
`default_nettype none

module frameBuffer import hostPkg::*; (
	input  logic     clk_llc,
	input  logic     resetx,
	input  logic     wrEn,
	input  wordAddrT wrAddr,
	input  bankT     wrBank,
	input  wordT     wrData,
	input  logic     hostCsx,
	input  logic     hostRdx,
	input  wordAddrT hostAddr,
	output wordT     hostData,
	output logic     hostWaitx
);

	wordT mem [0:2*BankWords-1];
	logic [1:0] csSync;
	logic [1:0] rdSync;
	logic csS;
	logic rdS;
	logic rdReq;
	logic rdIssued;
	logic ready;
	bankT rdBank;
	wordT rdWord;

	// ------------------------------------------------
	// memory, write port has priority
	// ------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (wrEn)
			mem[{wrBank, wrAddr}] <= wrData;
		else if (rdReq)
			rdWord <= mem[{rdBank, hostAddr}];
		if (rdIssued)
			hostData <= rdWord;
	end

	assign rdBank = (wrBank == Bank0) ? Bank1 : Bank0;

	// ------------------------------------------------
	// host strobe sync and read handshake
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			csSync <= 2'b11;
			rdSync <= 2'b11;
			rdIssued <= 1'b0;
			ready <= 1'b0;
		end
		else
		begin
			csSync <= {csSync[0], hostCsx};
			rdSync <= {rdSync[0], hostRdx};
			// a read blocked by a write simply retries next cycle
			rdIssued <= rdReq & ~wrEn;
			if (rdS)
				ready <= 1'b0;
			else if (rdIssued)
				ready <= 1'b1;
		end
	end

	assign csS = csSync[1];
	assign rdS = rdSync[1];
	assign rdReq = ~csS & ~rdS & ~ready & ~rdIssued;

	// raw chip-select, so wait drops as soon as the host selects
	assign hostWaitx = hostCsx | ready;

endmodule

`default_nettype wire

/* frameWriter.sv */
// assumes at most 120 kept lines per field; pixels past the bank capacity are dropped
`timescale 1ns/1ps
`default_nettype none

module frameWriter import hostPkg::*; #(
	parameter int PixelsPerLine = 180
) (
	input  logic      clk_llc,
	input  logic      resetx,
	pixelWriteIf.dst  pixel,
	output logic      wrEn,
	output wordAddrT  wrAddr,
	output bankT      wrBank,
	output wordT      wrData,
	output logic      irq0,
	output logic      irq1
);

	localparam int MaxLines = 120;
	localparam wordAddrT Capacity = wordAddrT'(PixelsPerLine * MaxLines);

	logic [1:0] irqCnt;

	// address counts writes done, so it is the next free word
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			wrEn <= 1'b0;
			wrAddr <= '0;
			wrBank <= Bank0;
			irqCnt <= 2'd0;
		end
		else
		begin
			wrEn <= pixel.valid && (wrAddr != Capacity);
			if (pixel.fieldEnd)
			begin
				wrAddr <= '0;
				wrBank <= (wrBank == Bank0) ? Bank1 : Bank0;
				irqCnt <= 2'd2;
			end
			else
			begin
				if (wrEn)
					wrAddr <= wrAddr + 1'b1;
				if (irqCnt != 2'd0)
					irqCnt <= irqCnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_llc)
	begin
		if (pixel.valid)
			wrData <= pixel.pixel;
	end

	// bank has already swapped, so the completed one is the other
	assign irq0 = (irqCnt != 2'd0) && (wrBank == Bank1);
	assign irq1 = (irqCnt != 2'd0) && (wrBank == Bank0);

endmodule

`default_nettype wire

/* ycbcrDecode.sv */
// fixed three-cycle latency; output is a grey level repacked as 5-6-5, not true colour
`timescale 1ns/1ps
`default_nettype none

module ycbcrDecode import videoPkg::*; (
	input  logic     clk_llc,
	input  logic     resetx,
	sampleIf.dst     sample,
	pixelWriteIf.src pixel
);

	logic signed [10:0] lumaDiff;
	logic signed [10:0] cbDiff;
	logic signed [10:0] crDiff;
	productT yTerm, rvTerm, gvTerm, guTerm, buTerm;
	productT redSum, greenSum, blueSum;
	logic [5:0] redTop, greenTop, blueTop;
	greyT grey;
	logic [1:0] validPipe;
	logic [1:0] endPipe;

	// returns bits 17..12 of a colour sum, clamped
	function automatic logic [5:0] clampTop(input productT sum);
		if (sum[20])
			return 6'h00;
		else if (sum[19] || sum[18])
			return 6'h3f;
		else
			return sum[17:12];
	endfunction

	// ------------------------------------------------
	// stage 1: offsets removed, coefficient products
	// ------------------------------------------------
	assign lumaDiff = $signed({1'b0, sample.luma, 2'b00}) - $signed({1'b0, OffsetY});
	assign cbDiff = $signed({1'b0, sample.cb, 2'b00}) - $signed({1'b0, OffsetC});
	assign crDiff = $signed({1'b0, sample.cr, 2'b00}) - $signed({1'b0, OffsetC});

	always_ff @(posedge clk_llc)
	begin
		yTerm <= lumaDiff * $signed({1'b0, CoefY});
		rvTerm <= crDiff * $signed({1'b0, CoefRV});
		gvTerm <= crDiff * $signed({1'b0, CoefGV});
		guTerm <= cbDiff * $signed({1'b0, CoefGU});
		buTerm <= cbDiff * $signed({1'b0, CoefBU});
		// stage 2
		redSum <= yTerm + rvTerm;
		greenSum <= yTerm - gvTerm - guTerm;
		blueSum <= yTerm + buTerm;
		// stage 3, grey in all three fields, green doubled to 6 bits
		pixel.pixel <= {grey, grey, 1'b0, grey};
	end

	// ------------------------------------------------
	// clamp and grey weighting
	// ------------------------------------------------
	always_comb
	begin
		redTop = clampTop(redSum);
		greenTop = clampTop(greenSum);
		blueTop = clampTop(blueSum);
		// red and blue are 17..13, so drop the lowest bit
		grey = greyT'(redTop[5:1] >> 2) + greyT'(greenTop >> 2) + greyT'(blueTop[5:1] >> 3);
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			validPipe <= 2'b00;
			endPipe <= 2'b00;
			pixel.valid <= 1'b0;
			pixel.fieldEnd <= 1'b0;
		end
		else
		begin
			validPipe <= {validPipe[0], sample.valid};
			endPipe <= {endPipe[0], sample.fieldEnd};
			pixel.valid <= validPipe[1];
			pixel.fieldEnd <= endPipe[1];
		end
	end

endmodule

`default_nettype wire

/* videoSync.sv */
// strobes are plain levels on clk_llc; only the odd field and every second line of it are kept
`timescale 1ns/1ps
`default_nettype none

module videoSync import videoPkg::*; #(
	parameter int DecimGroups = 2
) (
	input  logic   clk_llc,
	input  logic   resetx,
	input  logic   vref,
	input  logic   href,
	input  logic   odd,
	input  byteT   vpo,
	sampleIf.src   sample
);

	localparam int CntW = (DecimGroups > 1) ? $clog2(DecimGroups) : 1;

	logic vrefQ;
	logic hrefQ;
	logic oddQ;
	byteT vpoQ;
	logic keptField;
	logic keptFieldQ;
	logic lineKept;
	logic active;
	phaseT phase;
	logic [CntW-1:0] groupCnt;

	// ------------------------------------------------
	// input register and field / line selection
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			vrefQ <= 1'b0;
			hrefQ <= 1'b0;
			oddQ <= 1'b0;
			keptFieldQ <= 1'b0;
			lineKept <= 1'b0;
			sample.valid <= 1'b0;
			sample.fieldEnd <= 1'b0;
		end
		else
		begin
			vrefQ <= vref;
			hrefQ <= href;
			oddQ <= odd;
			keptFieldQ <= keptField;
			// toggled on the raw href edge so it is settled for the first registered byte
			if (!keptField)
				lineKept <= 1'b0;
			else if (href && !hrefQ)
				lineKept <= ~lineKept;
			// group complete once Cr is in
			sample.valid <= active && (phase == PhaseCr) && (groupCnt == '0);
			sample.fieldEnd <= keptFieldQ & ~keptField;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		vpoQ <= vpo;
	end

	assign keptField = oddQ & vrefQ;
	assign active = keptField & lineKept & hrefQ;

	// ------------------------------------------------
	// byte phase FSM and group decimation
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			phase <= PhaseCb;
			groupCnt <= '0;
		end
		else if (!active)
		begin
			phase <= PhaseCb;
			groupCnt <= '0;
		end
		else
		begin
			phase <= phaseT'(phase + 2'd1);
			if (phase == PhaseY2)
				groupCnt <= (groupCnt == CntW'(DecimGroups - 1)) ? '0 : groupCnt + 1'b1;
		end
	end

	// second Y of the group is never used
	always_ff @(posedge clk_llc)
	begin
		if (active)
		begin
			case (phase)
				PhaseCb: sample.cb <= vpoQ;
				PhaseY1: sample.luma <= vpoQ;
				PhaseCr: sample.cr <= vpoQ;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* pixelWriteIf.sv */
// grey pixel in 5-6-5 form, one per valid pulse; fieldEnd follows the last pixel of a field
`timescale 1ns/1ps
`default_nettype none

interface pixelWriteIf import videoPkg::*; ();

	logic valid;
	rgb565T pixel;
	logic fieldEnd;

	modport src (output valid, pixel, fieldEnd);
	modport dst (input valid, pixel, fieldEnd);

endinterface

`default_nettype wire

/* sampleIf.sv */
// one kept chroma/luma group per valid pulse; fieldEnd never coincides with valid
`timescale 1ns/1ps
`default_nettype none

interface sampleIf import videoPkg::*; ();

	logic valid;
	byteT luma;
	byteT cb;
	byteT cr;
	logic fieldEnd;

	modport src (output valid, luma, cb, cr, fieldEnd);
	modport dst (input valid, luma, cb, cr, fieldEnd);

endinterface

`default_nettype wire

/* hostPkg.sv */
// host side types; one bank holds up to 32K words, the buffer holds two banks
`default_nettype none

package hostPkg;

	typedef logic [14:0] wordAddrT;
	typedef logic [15:0] wordT;

	// bank being written; the host always reads the other one
	typedef enum logic
	{
		Bank0,
		Bank1
	} bankT;

	localparam int BankWords = 1 << $bits(wordAddrT);

endpackage

`default_nettype wire

/* videoPkg.sv */
// video side types and constants; coefficients carry 8 fraction bits, offsets apply to bytes x4
`default_nettype none

package videoPkg;

	// one byte of the 656 stream, upper byte of the decoder bus
	typedef logic [7:0] byteT;

	// byte position inside a Cb-Y-Cr-Y group
	typedef enum logic [1:0]
	{
		PhaseCb,
		PhaseY1,
		PhaseCr,
		PhaseY2
	} phaseT;

	// unsigned fixed point, two integer bits and eight fraction bits
	typedef logic [9:0] coefT;

	localparam coefT CoefY  = 10'd298;
	localparam coefT CoefRV = 10'd408;
	localparam coefT CoefGV = 10'd208;
	localparam coefT CoefGU = 10'd100;
	localparam coefT CoefBU = 10'd516;

	// black level and chroma zero, both on the x4 scale
	localparam logic [9:0] OffsetY = 10'd64;
	localparam logic [9:0] OffsetC = 10'd512;

	// products and colour sums, bit 20 is the sign
	typedef logic signed [20:0] productT;

	typedef logic [15:0] rgb565T;
	typedef logic [4:0] greyT;

endpackage

`default_nettype wire
